/* vlog.f */
bus_pkg.sv
uart_rx.sv
command_decoder.sv
bus_master.sv
bram_slave.sv
uart_tx.sv
uart_bus_top.sv
tb_uart_bus.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_uart_bus
RTL_TOP    := uart_bus_top
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_uart_bus.sv */
/*
 testbench for the uart to serial bus top level
 sends command frames on rx, decodes bytes from tx and checks
 every read against a reference copy of the block ram
*/

module tb_uart_bus;
	timeunit 1ns;
	timeprecision 1ps;
	import bus_pkg::*;

	// roughly 200 frames with margin
	localparam int          MAX_CYCLES  = 120000;
	localparam int          RESP_CYCLES = 2000;
	localparam int          NUM_RAND    = 20;
	localparam logic [31:0] LFSR_SEED   = 32'h74a2_9a8a;
	localparam logic [31:0] LFSR_MASK   = 32'hd000_0001;

	logic clk;
	logic reset;
	logic rx;
	logic tx;

	// reference copy of the ram, only written entries are ever read
	logic [DATA_LEN-1:0] model_mem [0:(1 << ADDR_LEN) - 1];
	// bytes decoded from tx, oldest first
	logic [DATA_LEN-1:0] rx_bytes [$];
	logic [31:0]         lfsr;
	int                  cycle_cnt = 0;
	int                  errors;
	int                  tests_passed;
	int                  tests_failed;
	int                  reads_sent;
	int                  rx_total;

	uart_bus_top i_uart_bus_top (.clk(clk), .reset(reset), .rx(rx), .tx(tx));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hard stop if a test never finishes
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        b;
		val = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? LFSR_MASK : 32'h0);
			val  = {val[30:0], b};
		end
		return val;
	endfunction

	// every wait ends 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic drive_bit(input logic v);
		rx = v;
		wait_cycles(CLKS_PER_BIT);
	endtask

	// start, data lsb first, stop
	task automatic send_byte(input logic [DATA_LEN-1:0] b);
		drive_bit(1'b0);
		for (int i = 0; i < DATA_LEN; i++) begin
			drive_bit(b[i]);
		end
		drive_bit(1'b1);
	endtask

	// top byte of the command word goes out first
	task automatic send_cmd(input logic write, input logic [ADDR_LEN-1:0] addr,
		input logic [DATA_LEN-1:0] data);
		cmd_word_t w;
		w              = '0;
		w.fields.write = write;
		w.fields.addr  = addr;
		w.fields.data  = data;
		for (int i = FRAME_BYTES - 1; i >= 0; i--) begin
			send_byte(w.bytes[i]);
		end
		if (write) begin
			model_mem[addr] = data;
		end else begin
			reads_sent++;
		end
	endtask

	task automatic expect_byte(input logic [DATA_LEN-1:0] exp);
		int                  waited;
		logic [DATA_LEN-1:0] got;
		waited = 0;
		while (rx_bytes.size() == 0 && waited < RESP_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		#1;
		assert (rx_bytes.size() != 0) else begin
			$display("no response on tx within %0d cycles at %0t", RESP_CYCLES, $time);
			errors++;
		end
		if (rx_bytes.size() != 0) begin
			got = rx_bytes.pop_front();
			assert (got == exp) else begin
				$display("ERR %0t tx: expected %02h got %02h", $time, exp, got);
				errors++;
			end
		end
	endtask

	// read frames carry a random data field that the DUT ignores
	task automatic read_check(input logic [ADDR_LEN-1:0] addr);
		send_cmd(1'b0, addr, DATA_LEN'(take_bits(DATA_LEN)));
		expect_byte(model_mem[addr]);
	endtask

	// nothing may show up on tx for n cycles
	task automatic expect_silence(input int n);
		wait_cycles(n);
		assert (rx_bytes.size() == 0) else begin
			$display("ERR %0t tx byte count: expected 0 got %0d", $time, rx_bytes.size());
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// tx monitor samples at negedge near each bit middle
	initial begin : tx_monitor
		logic [DATA_LEN-1:0] b;
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				// already half a cycle in so move on to mid start bit
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				for (int i = 0; i < DATA_LEN; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					b[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				assert (tx === 1'b1) else begin
					$display("framing error: stop bit low on tx at %0t", $time);
					errors++;
				end
				rx_bytes.push_back(b);
				rx_total++;
			end
		end
	end

	initial begin : main
		int                  errs;
		logic [ADDR_LEN-1:0] addrs [NUM_RAND];
		rx           = 1'b1;
		reset        = 1'b1;
		lfsr         = LFSR_SEED;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		reads_sent   = 0;
		rx_total     = 0;
		wait_cycles(16);
		reset = 1'b0;
		wait_cycles(20);

		// single write then read back
		errs = errors;
		send_cmd(1'b1, 12'h123, 8'h3c);
		read_check(12'h123);
		finish_test("write_read", errs);

		// random writes, reads in a shuffled order
		errs = errors;
		for (int i = 0; i < NUM_RAND; i++) begin
			addrs[i] = ADDR_LEN'(take_bits(ADDR_LEN));
			send_cmd(1'b1, addrs[i], DATA_LEN'(take_bits(DATA_LEN)));
		end
		// stride 7 is coprime with 20 so each address comes up once
		for (int i = 0; i < NUM_RAND; i++) begin
			read_check(addrs[(i * 7) % NUM_RAND]);
		end
		finish_test("random_rw", errs);

		// both ends of the address range
		errs = errors;
		send_cmd(1'b1, 12'h000, 8'ha5);
		send_cmd(1'b1, 12'hfff, 8'h5a);
		read_check(12'h000);
		read_check(12'hfff);
		finish_test("addr_range", errs);

		// lone byte, long gap, then a clean read frame
		errs = errors;
		send_byte(8'h8f);
		expect_silence(FRAME_TIMEOUT + 4 * CLKS_PER_BIT);
		read_check(12'h123);
		finish_test("frame_timeout", errs);

		// writes stay quiet and every read gave exactly one byte
		errs = errors;
		send_cmd(1'b1, 12'h456, 8'h99);
		expect_silence(400);
		assert (rx_total == reads_sent) else begin
			$display("ERR %0t rx_total: expected %0d got %0d", $time, reads_sent, rx_total);
			errors++;
		end
		finish_test("response_count", errs);

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* uart_bus_top.sv */
/*
 uart to serial bus top level
 rx frames become bus reads and writes on the block ram,
 read bytes go back out on tx
*/

module uart_bus_top (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx
);
	import bus_pkg::*;

	// input side
	logic                byte_valid;
	logic [DATA_LEN-1:0] byte_data;
	logic                cmd_valid;
	logic                cmd_write;
	logic [ADDR_LEN-1:0] cmd_addr;
	logic [DATA_LEN-1:0] cmd_data;
	// serial bus
	logic                master_valid;
	logic                tx_address;
	logic                tx_data;
	logic                write_en;
	logic                read_en;
	logic                slave_valid;
	logic                rx_data;
	// output side
	logic                rd_valid;
	logic [DATA_LEN-1:0] rd_data;

	uart_rx i_uart_rx (
		.clk(clk), .reset(reset), .rx(rx),
		.byte_valid(byte_valid), .byte_data(byte_data));

	command_decoder i_command_decoder (
		.clk(clk), .reset(reset),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.cmd_valid(cmd_valid), .cmd_write(cmd_write),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data));

	bus_master i_bus_master (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_write(cmd_write),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.master_valid(master_valid), .tx_address(tx_address), .tx_data(tx_data),
		.write_en(write_en), .read_en(read_en),
		.slave_valid(slave_valid), .rx_data(rx_data),
		.rd_valid(rd_valid), .rd_data(rd_data));

	bram_slave i_bram_slave (
		.clk(clk), .reset(reset),
		.master_valid(master_valid), .tx_address(tx_address), .tx_data(tx_data),
		.write_en(write_en), .read_en(read_en),
		.slave_valid(slave_valid), .rx_data(rx_data));

	uart_tx i_uart_tx (
		.clk(clk), .reset(reset),
		.rd_valid(rd_valid), .rd_data(rd_data), .tx(tx));

endmodule

/* uart_tx.sv */
/*
 uart transmitter
 sends each read byte as start bit, eight data bits lsb first
 and a stop bit
*/

module uart_tx (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          rd_valid,
	input  logic [bus_pkg::DATA_LEN-1:0]  rd_data,
	output logic                          tx
);
	import bus_pkg::*;

	logic                busy;
	logic [TICK_W-1:0]   clk_cnt;
	logic [3:0]          bit_cnt;
	logic [DATA_LEN+1:0] frame;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			// new byte only taken while the line is idle
			if (rd_valid) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == TICK_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'(DATA_LEN + 1)) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// stop, data, start from top to bottom
	always_ff @(posedge clk) begin
		if (!busy && rd_valid) begin
			frame <= {1'b1, rd_data, 1'b0};
		end else if (busy && clk_cnt == TICK_W'(CLKS_PER_BIT - 1)) begin
			frame <= {1'b1, frame[DATA_LEN+1:1]};
		end
	end

	assign tx = busy ? frame[0] : 1'b1;

endmodule

/* bram_slave.sv */
/*
 block ram bus slave
 4096 x 8 single port ram behind the serial bus, writes after the
 last data bit and returns read data msb first under slave_valid
*/

module bram_slave (
	input  logic clk,
	input  logic reset,
	input  logic master_valid,
	input  logic tx_address,
	input  logic tx_data,
	input  logic write_en,
	input  logic read_en,
	output logic slave_valid,
	output logic rx_data
);
	import bus_pkg::*;

	logic [DATA_LEN-1:0]   mem [0:(1 << ADDR_LEN) - 1];
	logic [BUS_CNT_W-1:0]  bit_cnt;
	logic [ADDR_LEN-1:0]   addr_sr;
	logic [DATA_LEN-2:0]   data_sr;
	logic [DATA_LEN-1:0]   rd_q;
	logic                  read_pend;
	logic [DATA_CNT_W-1:0] out_cnt;
	logic                  mem_we;

	// eighth data bit is taken straight off the wire
	assign mem_we = master_valid && write_en &&
		(bit_cnt == BUS_CNT_W'(ADDR_LEN + DATA_LEN - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt     <= '0;
			read_pend   <= 1'b0;
			slave_valid <= 1'b0;
			out_cnt     <= '0;
		end else begin
			bit_cnt   <= master_valid ? bit_cnt + 1'b1 : '0;
			// last address bit of a read
			read_pend <= master_valid && read_en && (bit_cnt == BUS_CNT_W'(ADDR_LEN - 1));
			if (read_pend) begin
				slave_valid <= 1'b1;
				out_cnt     <= '0;
			end else if (slave_valid) begin
				if (out_cnt == DATA_CNT_W'(DATA_LEN - 1)) begin
					slave_valid <= 1'b0;
				end
				out_cnt <= out_cnt + 1'b1;
			end
		end
	end

	// incoming serial address and data
	always_ff @(posedge clk) begin
		if (master_valid) begin
			if (bit_cnt < BUS_CNT_W'(ADDR_LEN)) begin
				addr_sr <= {addr_sr[ADDR_LEN-2:0], tx_address};
			end else begin
				data_sr <= {data_sr[DATA_LEN-3:0], tx_data};
			end
		end
	end

	// one synchronous port so it maps onto a block ram
	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[addr_sr] <= {data_sr, tx_data};
		end
		if (read_pend) begin
			rd_q <= mem[addr_sr];
		end
	end

	// msb first out of the ram register
	assign rx_data = rd_q[DATA_CNT_W'(DATA_LEN - 1) - out_cnt];

endmodule

/* bus_master.sv */
/*
 serial bus master
 shifts address and write data out msb first, one wire each,
 then collects the read byte from the slave and strobes it out
*/

module bus_master (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          cmd_valid,
	input  logic                          cmd_write,
	input  logic [bus_pkg::ADDR_LEN-1:0]  cmd_addr,
	input  logic [bus_pkg::DATA_LEN-1:0]  cmd_data,
	output logic                          master_valid,
	output logic                          tx_address,
	output logic                          tx_data,
	output logic                          write_en,
	output logic                          read_en,
	input  logic                          slave_valid,
	input  logic                          rx_data,
	output logic                          rd_valid,
	output logic [bus_pkg::DATA_LEN-1:0]  rd_data
);
	import bus_pkg::*;

	logic [1:0]            state;
	logic [ADDR_CNT_W-1:0] bit_cnt;
	logic                  is_write;
	logic [ADDR_LEN-1:0]   addr_sr;
	logic [DATA_LEN-1:0]   data_sr;
	logic [DATA_LEN-1:0]   rd_sr;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= MST_IDLE;
			bit_cnt  <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			case (state)
				MST_IDLE: begin
					// busy states simply never look at cmd_valid
					if (cmd_valid) begin
						state   <= MST_ADDR;
						bit_cnt <= '0;
					end
				end
				MST_ADDR: begin
					if (bit_cnt == ADDR_CNT_W'(ADDR_LEN - 1)) begin
						bit_cnt <= '0;
						state   <= is_write ? MST_WDATA : MST_RWAIT;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				MST_WDATA: begin
					if (bit_cnt == ADDR_CNT_W'(DATA_LEN - 1)) begin
						bit_cnt <= '0;
						state   <= MST_IDLE;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					// read wait counts bits only while the slave drives
					if (slave_valid) begin
						if (bit_cnt == ADDR_CNT_W'(DATA_LEN - 1)) begin
							bit_cnt  <= '0;
							rd_valid <= 1'b1;
							state    <= MST_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// shift registers for the serial lines
	always_ff @(posedge clk) begin
		if (state == MST_IDLE && cmd_valid) begin
			addr_sr  <= cmd_addr;
			data_sr  <= cmd_data;
			is_write <= cmd_write;
		end else begin
			if (state == MST_ADDR) begin
				addr_sr <= addr_sr << 1;
			end
			if (state == MST_WDATA) begin
				data_sr <= data_sr << 1;
			end
		end
		if (state == MST_RWAIT && slave_valid) begin
			rd_sr <= {rd_sr[DATA_LEN-2:0], rx_data};
		end
	end

	assign master_valid = (state == MST_ADDR) || (state == MST_WDATA);
	assign write_en     = master_valid && is_write;
	assign read_en      = (state == MST_ADDR) && !is_write;
	assign tx_address   = addr_sr[ADDR_LEN-1];
	assign tx_data      = data_sr[DATA_LEN-1];
	assign rd_data      = rd_sr;

endmodule

/* command_decoder.sv */
/*
 command decoder
 collects three uart bytes into a command word and strobes it out
 as a read or write, dropping partial frames after a silent gap
*/

module command_decoder (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          byte_valid,
	input  logic [bus_pkg::DATA_LEN-1:0]  byte_data,
	output logic                          cmd_valid,
	output logic                          cmd_write,
	output logic [bus_pkg::ADDR_LEN-1:0]  cmd_addr,
	output logic [bus_pkg::DATA_LEN-1:0]  cmd_data
);
	import bus_pkg::*;

	cmd_word_t             cmd_word;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [TIMEOUT_W-1:0]  idle_cnt;

	// frame alignment and timeout
	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt  <= '0;
			idle_cnt  <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			if (byte_valid) begin
				idle_cnt <= '0;
				if (byte_cnt == BYTE_CNT_W'(FRAME_BYTES - 1)) begin
					byte_cnt  <= '0;
					cmd_valid <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end else if (byte_cnt != '0) begin
				// partial frame waiting for more bytes
				if (idle_cnt == TIMEOUT_W'(FRAME_TIMEOUT)) begin
					byte_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	// oldest byte ends up in the top slot
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			cmd_word.bytes <= {cmd_word.bytes[FRAME_BYTES-2:0], byte_data};
		end
	end

	// decoded view, valid while cmd_valid is high
	assign cmd_write = cmd_word.fields.write;
	assign cmd_addr  = cmd_word.fields.addr;
	assign cmd_data  = cmd_word.fields.data;

endmodule

/* uart_rx.sv */
/*
 uart receiver
 synchronizes rx, finds the start edge, samples each bit mid-point
 and strobes the byte out once the stop bit checks high
*/

module uart_rx (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          rx,
	output logic                          byte_valid,
	output logic [bus_pkg::DATA_LEN-1:0]  byte_data
);
	import bus_pkg::*;

	logic                rx_meta;
	logic                rx_sync;
	logic                rx_prev;
	logic                busy;
	logic [TICK_W-1:0]   clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]          bit_idx;
	logic [DATA_LEN-1:0] shift_reg;
	logic                sample_now;

	// start bit sampled at half a bit, the rest a full bit apart
	assign sample_now = (bit_idx == '0) ? (clk_cnt == TICK_W'(CLKS_PER_BIT / 2 - 1)) :
		(clk_cnt == TICK_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta    <= 1'b1;
			rx_sync    <= 1'b1;
			rx_prev    <= 1'b1;
			busy       <= 1'b0;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			rx_meta    <= rx;
			rx_sync    <= rx_meta;
			rx_prev    <= rx_sync;
			byte_valid <= 1'b0;
			if (!busy) begin
				// falling edge opens a frame
				if (rx_prev && !rx_sync) begin
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (sample_now) begin
				clk_cnt <= '0;
				if (bit_idx == '0 && rx_sync) begin
					// glitch, not a real start bit
					busy <= 1'b0;
				end else if (bit_idx == 4'(DATA_LEN + 1)) begin
					// low stop bit drops the byte
					byte_valid <= rx_sync;
					busy       <= 1'b0;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// lsb arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (busy && sample_now && bit_idx != '0 && bit_idx != 4'(DATA_LEN + 1)) begin
			shift_reg <= {rx_sync, shift_reg[DATA_LEN-1:1]};
		end
	end

	assign byte_data = shift_reg;

endmodule

/* bus_pkg.sv */
/*
 serial bus subsystem shared definitions
 bus widths, uart bit timing, frame timeout and the command word
 which is filled byte by byte and decoded by field
*/

package bus_pkg;

	localparam int ADDR_LEN      = 12;
	localparam int DATA_LEN      = 8;
	localparam int CLKS_PER_BIT  = 16;
	// 40 bit times of silence drops a partial frame
	localparam int FRAME_TIMEOUT = 40 * CLKS_PER_BIT;
	localparam int FRAME_BYTES   = 3;

	// counter widths
	localparam int TICK_W     = $clog2(CLKS_PER_BIT);
	localparam int TIMEOUT_W  = $clog2(FRAME_TIMEOUT + 1);
	localparam int BYTE_CNT_W = $clog2(FRAME_BYTES);
	localparam int ADDR_CNT_W = $clog2(ADDR_LEN);
	localparam int DATA_CNT_W = $clog2(DATA_LEN);
	localparam int BUS_CNT_W  = $clog2(ADDR_LEN + DATA_LEN);

	// bus master FSM encoding
	localparam logic [1:0] MST_IDLE  = 2'd0;
	localparam logic [1:0] MST_ADDR  = 2'd1;
	localparam logic [1:0] MST_WDATA = 2'd2;
	localparam logic [1:0] MST_RWAIT = 2'd3;

	// first byte received sits in the top byte
	typedef union packed {
		logic [FRAME_BYTES-1:0][DATA_LEN-1:0] bytes;
		struct packed {
			logic                write;
			logic [2:0]          reserved;
			logic [ADDR_LEN-1:0] addr;
			logic [DATA_LEN-1:0] data;
		} fields;
	} cmd_word_t;

endpackage
